//--- testbench/tcb_lite_golden.mem
// columns: test_wen_address_size_wdata_rdata_mask_err, hex, one transaction per line
// rdata checked only under mask, err 1 expects range status, test f ends the list
1_1_00000040_0_ffffff11_00000000_00000000_0
1_1_00000041_0_eeeeee22_00000000_00000000_0
1_1_00000042_0_dddddd33_00000000_00000000_0
1_1_00000043_0_cccccc44_00000000_00000000_0
1_0_00000040_2_00000000_44332211_ffffffff_0
2_0_00000040_0_00000000_00000011_000000ff_0
2_0_00000041_0_00000000_00000022_000000ff_0
2_0_00000042_0_00000000_00000033_000000ff_0
2_0_00000043_0_00000000_00000044_000000ff_0
2_0_00000040_1_00000000_00002211_0000ffff_0
2_0_00000042_1_00000000_00004433_0000ffff_0
3_1_00000060_2_12345678_00000000_00000000_0
3_1_00000062_1_ffffbeef_00000000_00000000_0
3_0_00000060_2_00000000_beef5678_ffffffff_0
3_1_00000061_0_abababcd_00000000_00000000_0
3_0_00000060_2_00000000_beefcd78_ffffffff_0
4_1_00000000_2_0badf00d_00000000_00000000_0
4_1_000000fc_2_11112222_00000000_00000000_0
4_1_00000100_2_ffffffff_00000000_00000000_1
4_1_000001fe_1_00005555_00000000_00000000_1
4_0_00000100_2_00000000_00000000_00000000_1
4_0_00000000_2_00000000_0badf00d_ffffffff_0
4_0_000000fc_2_00000000_11112222_ffffffff_0
4_0_80000000_0_00000000_00000000_00000000_1
5_1_00000020_2_01020304_00000000_00000000_0
5_0_00000020_0_00000000_00000004_000000ff_0
5_0_00000023_0_00000000_00000001_000000ff_0
5_0_00000022_1_00000000_00000102_0000ffff_0
5_1_00000021_0_000000ee_00000000_00000000_0
5_0_00000020_2_00000000_0102ee04_ffffffff_0
5_0_00000400_2_00000000_00000000_00000000_1
5_0_00000041_0_00000000_00000022_000000ff_0
5_0_00000062_1_00000000_0000beef_0000ffff_0
f_0_00000000_0_00000000_00000000_00000000_0

//--- sources.f
logic/tcb_lite_pkg.sv
logic/tcb_lite_req_dly.sv
logic/tcb_lite_logsize2byteena.sv
logic/tcb_lite_mem.sv
logic/tcb_lite_top.sv
testbench/tcb_lite_clk_gen.sv
testbench/tcb_lite_assertions.sv
testbench/tcb_lite_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tcb_lite_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tcb_lite_tb.sv
`timescale 1ns/100ps
// testbench for the TCB-lite memory subsystem, replays golden vectors and checks each response
module tcb_lite_tb;
    import tcb_lite_pkg::*;

    localparam int DAT       = 32;
    localparam int ADR       = 32;
    localparam int MEM_DEPTH = 64;
    localparam int PERIOD    = 100;
    localparam int RST_CYC   = 5;
    localparam int MAX_VEC   = 64;
    // widest random gap between vectors
    localparam int MAX_IDLE  = 2;

    logic           clk;
    logic           arst_n;
    logic           vld;
    logic           wen;
    logic [ADR-1:0] adr;
    tcb_siz_e       siz;
    logic [DAT-1:0] wdt;
    logic           rdy;
    logic [DAT-1:0] rdt;
    logic [1:0]     sts;
    logic           err;

    // tst wen adr siz wdt rdt msk err, see the golden file header
    logic [143:0] vec [MAX_VEC];

    int   n_vec;
    int   err_cnt;
    int   chk_cnt;
    int   test_err;
    int   test_chk;
    int   tests_done;
    int   cycle;
    int   seed;
    logic loaded;
    // outstanding responses, vector index and falling edge it is due on
    int   pend_idx [$];
    int   pend_due [$];

    tcb_lite_clk_gen #(
        .PERIOD  (PERIOD),
        .RST_CYC (RST_CYC)
    ) clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    tcb_lite_top #(
        .DAT       (DAT),
        .ADR       (ADR),
        .MEM_DEPTH (MEM_DEPTH)
    ) dut_i (
        .clk (clk), .arst_n (arst_n),
        .vld (vld), .wen (wen), .adr (adr), .siz (siz), .wdt (wdt),
        .rdy (rdy), .rdt (rdt), .sts (sts), .err (err)
    );

    bind tcb_lite_top tcb_lite_assertions #(
        .DAT (DAT)
    ) asrt_i (
        .clk (clk), .arst_n (arst_n), .vld (vld), .rdy (rdy),
        .mem_vld (mem_vld), .mem_byt (mem_byt), .siz (siz)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'h1: return "byte writes then word read";
            4'h2: return "byte and halfword reads per offset";
            4'h3: return "partial writes keep other bytes";
            4'h4: return "address range error";
            4'h5: return "back-to-back transfers";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input string name, input logic [DAT-1:0] got,
                           input logic [DAT-1:0] exp);
        chk_cnt++;
        test_chk++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic drive_vector(input int i);
        vld = 1'b1;
        wen = vec[i][136];
        adr = vec[i][135:104];
        siz = tcb_siz_e'(vec[i][101:100]);
        wdt = vec[i][99:68];
    endtask

    // junk on the fields, nothing may change while vld is low
    task automatic drive_idle();
        vld = 1'b0;
        wen = 1'b1;
        adr = $random(seed);
        wdt = $random(seed);
    endtask

    task automatic report_test(input int i);
        $display("test %0d %s: %0d checks, %0d errors",
                 vec[i][143:140], test_name(vec[i][143:140]), test_chk, test_err);
        tests_done++;
        test_chk = 0;
        test_err = 0;
    endtask

    task automatic check_response(input int i);
        logic [DAT-1:0] msk;
        logic [DAT-1:0] exp_rdt;
        logic           exp_err;
        logic [1:0]     exp_sts;
        msk     = vec[i][35:4];
        exp_rdt = vec[i][67:36];
        exp_err = vec[i][0];
        // range error is the only non-ok status
        exp_sts = exp_err ? TCB_STS_RANGE : TCB_STS_OK;
        compare("rdt", rdt & msk, exp_rdt & msk);
        compare("err", DAT'(err), DAT'(exp_err));
        compare("sts", DAT'(sts), DAT'(exp_sts));
        // last vector of a test closes it
        if (vec[i+1][143:140] !== vec[i][143:140]) begin
            report_test(i);
        end
    endtask

    task automatic run_due_checks();
        while (pend_idx.size() > 0 && pend_due[0] == cycle) begin
            check_response(pend_idx[0]);
            void'(pend_idx.pop_front());
            void'(pend_due.pop_front());
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int idle;
        int asrt_fail;
        vld        = 1'b0;
        wen        = 1'b0;
        adr        = '0;
        siz        = SIZ_BYTE;
        wdt        = '0;
        err_cnt    = 0;
        chk_cnt    = 0;
        test_err   = 0;
        test_chk   = 0;
        tests_done = 0;
        cycle      = 0;
        loaded     = 1'b0;
        seed       = 32'h0e5e_2cd3;

        $readmemh("testbench/tcb_lite_golden.mem", vec);
        n_vec = 0;
        while (n_vec < MAX_VEC - 1 && vec[n_vec][143:140] inside {[4'h1:4'h5]}) begin
            n_vec++;
        end
        if (n_vec == 0) begin
            $display("golden file could not be read or holds no vectors");
            err_cnt++;
        end else if (vec[n_vec][143:140] !== 4'hf) begin
            $display("golden file has a bad test id or no end marker at line %0d", n_vec);
            err_cnt++;
        end
        loaded = 1'b1;

        wait (arst_n === 1'b1);
        @(posedge clk);
        for (int i = 0; i < n_vec; i++) begin
            @(negedge clk);
            cycle++;
            run_due_checks();
            // back-to-back test runs without gaps
            if (vec[i][143:140] != 4'h5) begin
                idle = $unsigned($random(seed)) % (MAX_IDLE + 1);
                repeat (idle) begin
                    drive_idle();
                    @(negedge clk);
                    cycle++;
                    run_due_checks();
                end
            end
            drive_vector(i);
            pend_idx.push_back(i);
            pend_due.push_back(cycle + TCB_DLY);
        end

        // drain the responses still in flight
        while (pend_idx.size() > 0) begin
            @(negedge clk);
            cycle++;
            run_due_checks();
            drive_idle();
        end

        asrt_fail = dut_i.asrt_i.fail_cnt;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_done, chk_cnt, err_cnt, asrt_fail);
        if (err_cnt == 0 && asrt_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // at most three cycles per vector plus drain, four leaves margin
    initial begin
        wait (loaded === 1'b1);
        #((n_vec * 4 + RST_CYC + TCB_DLY + 2) * PERIOD);
        $display("timeout: %0d responses never arrived before the time limit",
                 pend_idx.size());
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- testbench/tcb_lite_assertions.sv
`timescale 1ns/100ps
// handshake and byte-enable protocol assertions, bound into the TCB-lite top level
module tcb_lite_assertions #(
    parameter int DAT = 32
)(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               vld,
    input  logic               rdy,
    input  logic               mem_vld,
    input  logic [DAT/8-1:0]   mem_byt,
    input  logic [1:0]         siz
);

    // read by the testbench at the end of the run
    int unsigned fail_cnt = 0;

    ////////////////////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////////////////////

    // memory never stalls once out of reset
    rdy_high_a: assert property (@(posedge clk) disable iff (!arst_n) rdy)
        else begin
            $error("rdy low outside reset");
            fail_cnt <= fail_cnt + 1;
        end

    ////////////////////////////////////////////////////////////////////////////
    // byte enables
    ////////////////////////////////////////////////////////////////////////////

    // a request always touches some lane
    byt_nonzero_a: assert property (@(posedge clk) disable iff (!arst_n)
        mem_vld |-> (mem_byt != '0))
        else begin
            $error("mem_byt is zero while mem_vld is high");
            fail_cnt <= fail_cnt + 1;
        end

    // lane count matches the logarithmic size
    byt_count_a: assert property (@(posedge clk) disable iff (!arst_n)
        (vld && rdy) |-> ($countones(mem_byt) == (1 << siz)))
        else begin
            $error("mem_byt lane count does not match siz");
            fail_cnt <= fail_cnt + 1;
        end

endmodule

//--- testbench/tcb_lite_clk_gen.sv
`timescale 1ns/100ps
// clock and reset source for the TCB-lite testbench, free running clock with an initial reset
module tcb_lite_clk_gen #(
    parameter int PERIOD  = 100,
    parameter int RST_CYC = 5
)(
    output logic clk,
    output logic arst_n
);

    // free running, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // reset held over the first RST_CYC rising edges, released on a falling edge
    initial begin
        arst_n = 1'b0;
        #(RST_CYC*PERIOD) arst_n = 1'b1;
    end

endmodule

//--- logic/tcb_lite_top.sv
`timescale 1ns/100ps
// TCB-lite memory subsystem top level wiring converter, delay line and SRAM to loose bus ports
module tcb_lite_top #(
    parameter int DAT       = tcb_lite_pkg::TCB_DAT_DEF,
    parameter int ADR       = tcb_lite_pkg::TCB_ADR_DEF,
    parameter int MEM_DEPTH = 256
)(
    input  logic                     clk,
    input  logic                     arst_n,
    // manager request
    input  logic                     vld,
    input  logic                     wen,
    input  logic [ADR-1:0]           adr,
    input  tcb_lite_pkg::tcb_siz_e   siz,
    input  logic [DAT-1:0]           wdt,
    // response TCB_DLY cycles after transfer
    output logic                     rdy,
    output logic [DAT-1:0]           rdt,
    output logic [1:0]               sts,
    output logic                     err
);
    import tcb_lite_pkg::*;

    localparam int BYT = DAT/8;
    localparam int OFF = $clog2(BYT);

    // transfer strobe
    logic trn;

    // memory side bus
    logic                   mem_vld;
    logic                   mem_wen;
    logic [ADR-1:0]         mem_adr;
    logic [BYT-1:0]         mem_byt;
    logic [DAT-1:0]         mem_wdt;
    logic                   mem_rdy;
    logic [DAT-1:0]         mem_rdt;
    logic [1:0]             mem_sts;
    logic                   mem_err;

    // delayed request info
    logic [OFF-1:0]         rsp_off;
    tcb_siz_e               rsp_siz;

    assign trn = vld & rdy;

    ////////////////////////////////////////////////////////////////////////////
    // submodules
    ////////////////////////////////////////////////////////////////////////////

    tcb_lite_logsize2byteena #(
        .DAT (DAT),
        .ADR (ADR)
    ) conv_i (
        .vld     (vld),     .wen     (wen),     .adr     (adr),
        .siz     (siz),     .wdt     (wdt),
        .rdy     (rdy),     .rdt     (rdt),     .sts     (sts),     .err     (err),
        .mem_vld (mem_vld), .mem_wen (mem_wen), .mem_adr (mem_adr),
        .mem_byt (mem_byt), .mem_wdt (mem_wdt),
        .mem_rdy (mem_rdy), .mem_rdt (mem_rdt), .mem_sts (mem_sts), .mem_err (mem_err),
        .rsp_off (rsp_off), .rsp_siz (rsp_siz)
    );

    // offset comes from the low address bits
    tcb_lite_req_dly #(
        .DAT (DAT)
    ) dly_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .trn     (trn),
        .req_off (adr[OFF-1:0]),
        .req_siz (siz),
        .rsp_off (rsp_off),
        .rsp_siz (rsp_siz)
    );

    tcb_lite_mem #(
        .DAT       (DAT),
        .ADR       (ADR),
        .MEM_DEPTH (MEM_DEPTH)
    ) mem_i (
        .clk     (clk),     .arst_n  (arst_n),
        .mem_vld (mem_vld), .mem_wen (mem_wen), .mem_adr (mem_adr),
        .mem_byt (mem_byt), .mem_wdt (mem_wdt),
        .mem_rdy (mem_rdy), .mem_rdt (mem_rdt), .mem_sts (mem_sts), .mem_err (mem_err)
    );

endmodule

//--- logic/tcb_lite_mem.sv
`timescale 1ns/100ps
// byte-enable SRAM subordinate with fixed response delay, used as the TCB-lite memory
module tcb_lite_mem #(
    parameter int DAT       = 32,
    parameter int ADR       = 32,
    parameter int MEM_DEPTH = 256
)(
    input  logic               clk,
    input  logic               arst_n,
    // request
    input  logic               mem_vld,
    input  logic               mem_wen,
    input  logic [ADR-1:0]     mem_adr,
    input  logic [DAT/8-1:0]   mem_byt,
    input  logic [DAT-1:0]     mem_wdt,
    // response
    output logic               mem_rdy,
    output logic [DAT-1:0]     mem_rdt,
    output logic [1:0]         mem_sts,
    output logic               mem_err
);
    import tcb_lite_pkg::*;

    localparam int BYT = DAT/8;
    localparam int OFF = $clog2(BYT);
    // word index width from the byte address
    localparam int IDX = ADR - OFF;
    // array index width
    localparam int AW  = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam logic [IDX-1:0] LIMIT = IDX'(MEM_DEPTH);

    logic                trn;
    logic [IDX-1:0]      word_idx;
    logic                range_err;
    logic [BYT-1:0][7:0] wdt_b;

    // storage
    logic [BYT-1:0][7:0] mem_q [MEM_DEPTH];

    // response pipeline
    logic [DAT-1:0]      rdt_q [TCB_DLY];
    logic [1:0]          sts_q [TCB_DLY];
    logic                err_q [TCB_DLY];

    // never stalls
    assign mem_rdy = 1'b1;
    assign trn     = mem_vld & mem_rdy;

    // word address and range check
    assign word_idx  = mem_adr[ADR-1:OFF];
    assign range_err = (word_idx >= LIMIT);
    assign wdt_b     = mem_wdt;

    ////////////////////////////////////////////////////////////////////////////
    // array write
    ////////////////////////////////////////////////////////////////////////////

    // out of range writes are dropped
    always_ff @(posedge clk) begin
        if (trn && mem_wen && !range_err) begin
            for (int b = 0; b < BYT; b++) begin
                if (mem_byt[b]) begin
                    mem_q[word_idx[AW-1:0]][b] <= wdt_b[b];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // response registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < TCB_DLY; i++) begin
                rdt_q[i] <= '0;
                sts_q[i] <= TCB_STS_OK;
                err_q[i] <= 1'b0;
            end
        end else begin
            // read data only refreshed on reads
            if (trn && !mem_wen) begin
                rdt_q[0] <= range_err ? '0 : mem_q[word_idx[AW-1:0]];
            end
            // error only flagged in the cycle of a bad access
            sts_q[0] <= (trn && range_err) ? TCB_STS_RANGE : TCB_STS_OK;
            err_q[0] <= trn & range_err;
            for (int i = 1; i < TCB_DLY; i++) begin
                rdt_q[i] <= rdt_q[i-1];
                sts_q[i] <= sts_q[i-1];
                err_q[i] <= err_q[i-1];
            end
        end
    end

    assign mem_rdt = rdt_q[TCB_DLY-1];
    assign mem_sts = sts_q[TCB_DLY-1];
    assign mem_err = err_q[TCB_DLY-1];

endmodule

//--- logic/tcb_lite_logsize2byteena.sv
`timescale 1ns/100ps
// converts logarithmic-size TCB-lite requests to byte-enable form for the memory side
module tcb_lite_logsize2byteena #(
    parameter int DAT = 32,
    parameter int ADR = 32
)(
    // manager side request
    input  logic                         vld,
    input  logic                         wen,
    input  logic [ADR-1:0]               adr,
    input  tcb_lite_pkg::tcb_siz_e       siz,
    input  logic [DAT-1:0]               wdt,
    // manager side response
    output logic                         rdy,
    output logic [DAT-1:0]               rdt,
    output logic [1:0]                   sts,
    output logic                         err,
    // memory side request
    output logic                         mem_vld,
    output logic                         mem_wen,
    output logic [ADR-1:0]               mem_adr,
    output logic [DAT/8-1:0]             mem_byt,
    output logic [DAT-1:0]               mem_wdt,
    // memory side response
    input  logic                         mem_rdy,
    input  logic [DAT-1:0]               mem_rdt,
    input  logic [1:0]                   mem_sts,
    input  logic                         mem_err,
    // delayed request info for read alignment
    input  logic [$clog2(DAT/8)-1:0]     rsp_off,
    input  tcb_lite_pkg::tcb_siz_e       rsp_siz
);
    import tcb_lite_pkg::*;

    localparam int BYT = DAT/8;
    localparam int OFF = $clog2(BYT);

    // request offset and masks
    logic [OFF-1:0] req_off;
    logic [OFF-1:0] req_msk;
    logic [OFF-1:0] rsp_msk;
    // base offset of the aligned group at response time
    logic [OFF-1:0] rsp_base;

    // byte views of the data busses
    logic [BYT-1:0][7:0] wdt_b;
    logic [BYT-1:0][7:0] mem_wdt_b;
    logic [BYT-1:0][7:0] mem_rdt_b;
    logic [BYT-1:0][7:0] rdt_b;

    ////////////////////////////////////////////////////////////////////////////
    // helper functions
    ////////////////////////////////////////////////////////////////////////////

    // offset bits at or above the size select the group
    function automatic logic [OFF-1:0] size_mask(input tcb_siz_e s);
        logic [OFF-1:0] m;
        for (int i = 0; i < OFF; i++) begin
            m[i] = (i >= int'(s));
        end
        return m;
    endfunction

    // OR of each bit with all bits above it
    function automatic logic [OFF-1:0] prefix_or(input logic [OFF-1:0] val);
        logic [OFF-1:0] p;
        p[OFF-1] = val[OFF-1];
        for (int i = OFF-1; i > 0; i--) begin
            p[i-1] = p[i] | val[i-1];
        end
        return p;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // request path
    ////////////////////////////////////////////////////////////////////////////

    // handshake and control straight through
    assign mem_vld = vld;
    assign mem_wen = wen;
    assign mem_adr = adr;

    assign req_off = adr[OFF-1:0];
    assign req_msk = size_mask(siz);

    // enable every lane of the naturally aligned group
    always_comb begin
        for (int i = 0; i < BYT; i++) begin
            mem_byt[i] = ((req_off & req_msk) == (OFF'(i) & req_msk));
        end
    end

    // low order bytes copied into each lane of the group
    assign wdt_b = wdt;
    always_comb begin
        for (int i = 0; i < BYT; i++) begin
            mem_wdt_b[i] = wdt_b[OFF'(i) & ~req_msk];
        end
    end
    assign mem_wdt = mem_wdt_b;

    ////////////////////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////////////////////

    // same group base as the byte enables used
    assign rsp_msk  = size_mask(rsp_siz);
    assign rsp_base = rsp_off & rsp_msk;

    // shift addressed bytes down towards lane 0
    assign mem_rdt_b = mem_rdt;
    always_comb begin
        for (int i = 0; i < BYT; i++) begin
            rdt_b[i] = mem_rdt_b[(~prefix_or(OFF'(i)) & rsp_base) | OFF'(i)];
        end
    end
    assign rdt = rdt_b;

    // status, error and ready pass up unchanged
    assign sts = mem_sts;
    assign err = mem_err;
    assign rdy = mem_rdy;

endmodule

//--- logic/tcb_lite_req_dly.sv
`timescale 1ns/100ps
// request offset and size delay line, keeps read alignment info paired with each response
module tcb_lite_req_dly #(
    // data width, sets the offset width
    parameter int DAT = 32
)(
    input  logic                         clk,
    input  logic                         arst_n,
    // request side
    input  logic                         trn,
    input  logic [$clog2(DAT/8)-1:0]     req_off,
    input  tcb_lite_pkg::tcb_siz_e       req_siz,
    // response side, TCB_DLY cycles later
    output logic [$clog2(DAT/8)-1:0]     rsp_off,
    output tcb_lite_pkg::tcb_siz_e       rsp_siz
);
    import tcb_lite_pkg::*;

    // byte lanes and offset bits
    localparam int BYT = DAT/8;
    localparam int OFF = $clog2(BYT);

    // one entry per response cycle
    logic [OFF-1:0] off_q [TCB_DLY];
    tcb_siz_e       siz_q [TCB_DLY];

    ////////////////////////////////////////////////////////////////////////////
    // register chain
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < TCB_DLY; i++) begin
                off_q[i] <= '0;
                siz_q[i] <= SIZ_BYTE;
            end
        end else begin
            // first stage only follows real transfers
            if (trn) begin
                off_q[0] <= req_off;
                siz_q[0] <= req_siz;
            end
            // remaining stages march with the memory pipeline
            for (int i = 1; i < TCB_DLY; i++) begin
                off_q[i] <= off_q[i-1];
                siz_q[i] <= siz_q[i-1];
            end
        end
    end

    // last stage lines up with the memory response
    assign rsp_off = off_q[TCB_DLY-1];
    assign rsp_siz = siz_q[TCB_DLY-1];

endmodule

//--- logic/tcb_lite_pkg.sv
// shared TCB-lite size encoding, response delay and status codes, imported by RTL and testbench
package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // transfer size
    ////////////////////////////////////////////////////////////////////////////

    // logarithmic size, byte count is 2**value
    typedef enum logic [1:0] {
        SIZ_BYTE  = 2'd0,
        SIZ_HALF  = 2'd1,
        SIZ_WORD  = 2'd2,
        // only legal on a 64-bit data bus
        SIZ_DWORD = 2'd3
    } tcb_siz_e;

    ////////////////////////////////////////////////////////////////////////////
    // bus timing and defaults
    ////////////////////////////////////////////////////////////////////////////

    // cycles from request transfer to response
    // memory and delay line both rely on this being at least 1
    localparam int TCB_DLY = 1;

    // default data width in bits
    localparam int TCB_DAT_DEF = 32;

    // default byte address width
    localparam int TCB_ADR_DEF = 32;

    ////////////////////////////////////////////////////////////////////////////
    // response status
    ////////////////////////////////////////////////////////////////////////////

    // access completed normally
    localparam logic [1:0] TCB_STS_OK    = 2'd0;

    // word address beyond the memory depth
    localparam logic [1:0] TCB_STS_RANGE = 2'd1;

endpackage
